// ==== src/lcd_image_pkg.sv ====
package lcd_image_pkg;

    // Screen coordinate wide enough for a 480 pixel axis
    typedef logic [8:0] coord_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // Inclusive bounds
    typedef struct packed {
        coord_t x0;
        coord_t x1;
        coord_t y0;
        coord_t y1;
    } lcd_rect_t;

    typedef enum logic [1:0] {
        CMD_CONFIGURE,
        CMD_FILL_RECT,
        CMD_WRITE_RECT
    } lcd_cmd_e;

    typedef struct packed {
        lcd_cmd_e  opcode;
        lcd_rect_t rect;
        pixel_t    fill;
    } lcd_request_t;

    // rs low marks a command byte
    typedef struct packed {
        logic        rs;
        logic [15:0] data;
    } lcd_word_t;

    typedef struct packed {
        pixel_t pixel;
        logic   start;
    } image_beat_t;

    typedef enum logic [3:0] {
        ST_START,
        ST_CONFIGURE,
        ST_FILL,
        ST_IDLE,
        ST_OPEN,
        ST_TRANSFER,
        ST_DRAIN,
        ST_ABORT,
        ST_ACK
    } seq_state_e;

    localparam logic [7:0] OP_SOFT_RESET   = 8'h01;
    localparam logic [7:0] OP_DISPLAY_ON   = 8'h29;
    localparam logic [7:0] OP_COLUMN_ADDR  = 8'h2a;
    localparam logic [7:0] OP_ROW_ADDR     = 8'h2b;
    localparam logic [7:0] OP_MEMORY_WRITE = 8'h2c;

    localparam pixel_t FILL_COLOUR = 16'h0001;

    // Write strobe phases of the panel bus
    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;

endpackage

// ==== src/frame_sequencer.sv ====
`timescale 1ns/100ps

module frame_sequencer #(
    parameter int LcdWidth      = 480,
    parameter int LcdHeight     = 320,
    parameter int ImageX        = 0,
    parameter int ImageY        = 0,
    parameter int ImageWidth    = 64,
    parameter int ImageHeight   = 64,
    parameter int TimeoutCycles = 4000
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        refresh_req,
    output logic                        refresh_ack,
    output lcd_image_pkg::lcd_request_t request,
    output logic                        req_valid,
    input  logic                        req_ready,
    output logic                        window_open,
    input  logic                        pixel_taken,
    input  logic                        pix_valid,
    input  logic                        pix_ready,
    output logic                        abort,
    output logic                        image_cancel,
    output logic                        configuring,
    output logic                        running,
    output logic                        busy
);

    localparam int PixelCount = ImageWidth * ImageHeight;
    localparam int CountWidth = $clog2(PixelCount + 1);
    localparam int TimerWidth = $clog2(TimeoutCycles + 1);

    localparam lcd_image_pkg::lcd_request_t ConfigRequest = '{
        opcode: lcd_image_pkg::CMD_CONFIGURE,
        rect:   '0,
        fill:   '0
    };

    // Clear the whole screen
    localparam lcd_image_pkg::lcd_request_t FillRequest = '{
        opcode: lcd_image_pkg::CMD_FILL_RECT,
        rect:   '{x0: '0, x1: 9'(LcdWidth - 1), y0: '0, y1: 9'(LcdHeight - 1)},
        fill:   lcd_image_pkg::FILL_COLOUR
    };

    localparam lcd_image_pkg::lcd_request_t WriteRequest = '{
        opcode: lcd_image_pkg::CMD_WRITE_RECT,
        rect:   '{x0: 9'(ImageX), x1: 9'(ImageX + ImageWidth - 1),
                  y0: 9'(ImageY), y1: 9'(ImageY + ImageHeight - 1)},
        fill:   '0
    };

    lcd_image_pkg::seq_state_e state;
    logic [CountWidth-1:0]     taken_count;
    logic [TimerWidth-1:0]     timer;
    logic                      activity;
    logic                      expired;
    logic                      last_pixel;

    // Any pixel moving on either side of the skid buffer keeps the frame alive
    assign activity   = pixel_taken || (pix_valid && pix_ready);
    assign expired    = !activity && (timer == '0);
    assign last_pixel = pixel_taken && (taken_count == CountWidth'(PixelCount - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= lcd_image_pkg::ST_START;
            req_valid    <= 1'b0;
            window_open  <= 1'b0;
            abort        <= 1'b0;
            image_cancel <= 1'b0;
            refresh_ack  <= 1'b0;
            configuring  <= 1'b0;
            running      <= 1'b0;
            busy         <= 1'b0;
            taken_count  <= '0;
            timer        <= '0;
        end else begin
            if (pixel_taken) begin
                taken_count <= taken_count + 1'b1;
            end
            if (activity || state == lcd_image_pkg::ST_OPEN) begin
                timer <= TimerWidth'(TimeoutCycles);
            end else if (timer != '0) begin
                timer <= timer - 1'b1;
            end

            case (state)
                lcd_image_pkg::ST_START: begin
                    configuring <= 1'b1;
                    busy        <= 1'b1;
                    request     <= ConfigRequest;
                    req_valid   <= 1'b1;
                    state       <= lcd_image_pkg::ST_CONFIGURE;
                end
                lcd_image_pkg::ST_CONFIGURE: begin
                    // Engine ready again after the handshake means the command is done
                    if (req_valid) begin
                        if (req_ready) begin
                            req_valid <= 1'b0;
                        end
                    end else if (req_ready) begin
                        request   <= FillRequest;
                        req_valid <= 1'b1;
                        state     <= lcd_image_pkg::ST_FILL;
                    end
                end
                lcd_image_pkg::ST_FILL: begin
                    if (req_valid) begin
                        if (req_ready) begin
                            req_valid <= 1'b0;
                        end
                    end else if (req_ready) begin
                        configuring <= 1'b0;
                        running     <= 1'b1;
                        busy        <= 1'b0;
                        state       <= lcd_image_pkg::ST_IDLE;
                    end
                end
                lcd_image_pkg::ST_IDLE: begin
                    if (refresh_req) begin
                        busy        <= 1'b1;
                        request     <= WriteRequest;
                        req_valid   <= 1'b1;
                        window_open <= 1'b1;
                        taken_count <= '0;
                        state       <= lcd_image_pkg::ST_OPEN;
                    end
                end
                lcd_image_pkg::ST_OPEN: begin
                    if (req_ready) begin
                        req_valid <= 1'b0;
                        state     <= lcd_image_pkg::ST_TRANSFER;
                    end
                end
                lcd_image_pkg::ST_TRANSFER: begin
                    if (last_pixel) begin
                        window_open <= 1'b0;
                        state       <= lcd_image_pkg::ST_DRAIN;
                    end else if (expired) begin
                        abort        <= 1'b1;
                        image_cancel <= 1'b1;
                        window_open  <= 1'b0;
                        state        <= lcd_image_pkg::ST_ABORT;
                    end
                end
                lcd_image_pkg::ST_DRAIN: begin
                    // Last pixels still leaving the buffer
                    if (req_ready) begin
                        refresh_ack <= 1'b1;
                        state       <= lcd_image_pkg::ST_ACK;
                    end else if (expired) begin
                        abort        <= 1'b1;
                        image_cancel <= 1'b1;
                        state        <= lcd_image_pkg::ST_ABORT;
                    end
                end
                lcd_image_pkg::ST_ABORT: begin
                    abort        <= 1'b0;
                    image_cancel <= 1'b0;
                    refresh_ack  <= 1'b1;
                    state        <= lcd_image_pkg::ST_ACK;
                end
                lcd_image_pkg::ST_ACK: begin
                    if (!refresh_req) begin
                        refresh_ack <= 1'b0;
                        busy        <= 1'b0;
                        state       <= lcd_image_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= lcd_image_pkg::ST_START;
                end
            endcase
        end
    end

endmodule

// ==== src/pixel_skid_buffer.sv ====
`timescale 1ns/100ps

module pixel_skid_buffer (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       window_open,
    input  lcd_image_pkg::image_beat_t image_beat,
    input  logic                       image_valid,
    output logic                       image_ready,
    output logic                       pixel_taken,
    output lcd_image_pkg::pixel_t      pixel,
    output logic                       pix_valid,
    input  logic                       pix_ready
);

    lcd_image_pkg::pixel_t slot [2];
    logic [1:0]            count;
    logic                  seen_start;
    logic                  window_q;
    logic                  take;
    logic                  pop;

    // Nothing is accepted in the cycle the window opens, while old contents clear
    assign image_ready = window_open && window_q && (count != 2'd2);
    assign take        = image_valid && image_ready;
    assign pixel_taken = take && (seen_start || image_beat.start);
    assign pop         = pix_valid && pix_ready;
    assign pixel       = slot[0];
    assign pix_valid   = (count != 2'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            count      <= 2'd0;
            seen_start <= 1'b0;
            window_q   <= 1'b0;
        end else begin
            window_q <= window_open;
            if (window_open && !window_q) begin
                // Leftovers of an aborted frame are dropped here
                count      <= 2'd0;
                seen_start <= 1'b0;
            end else begin
                if (pixel_taken) begin
                    seen_start <= 1'b1;
                end
                count <= count + 2'(pixel_taken) - 2'(pop);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            slot[0] <= slot[1];
        end
        if (pixel_taken) begin
            slot[(count == 2'd1 && !pop) ? 1 : 0] <= image_beat.pixel;
        end
    end

endmodule

// ==== src/lcd_command_engine.sv ====
`timescale 1ns/100ps

module lcd_command_engine (
    input  logic                        clock,
    input  logic                        reset,
    input  lcd_image_pkg::lcd_request_t request,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  lcd_image_pkg::pixel_t       pixel,
    input  logic                        pix_valid,
    output logic                        pix_ready,
    input  logic                        abort,
    output lcd_image_pkg::lcd_word_t    word,
    output logic                        word_valid,
    input  logic                        word_ready,
    output logic                        frame_end
);

    typedef enum logic [1:0] {
        E_IDLE,
        E_HEADER,
        E_DATA,
        E_END
    } engine_state_e;

    engine_state_e               state;
    lcd_image_pkg::lcd_request_t cmd;
    logic [2:0]                  step;
    logic [19:0]                 remaining;
    logic                        word_move;
    logic                        last_header;
    logic                        is_write;

    // Command bytes and window coordinates ahead of the pixel data
    function automatic lcd_image_pkg::lcd_word_t header_word(
        input lcd_image_pkg::lcd_request_t c,
        input logic [2:0]                  s
    );
        lcd_image_pkg::lcd_word_t w;
        w.rs   = 1'b1;
        w.data = '0;
        if (c.opcode == lcd_image_pkg::CMD_CONFIGURE) begin
            w.rs        = 1'b0;
            w.data[7:0] = (s == 3'd0) ? lcd_image_pkg::OP_SOFT_RESET
                                      : lcd_image_pkg::OP_DISPLAY_ON;
        end else begin
            case (s)
                3'd0: begin
                    w.rs        = 1'b0;
                    w.data[7:0] = lcd_image_pkg::OP_COLUMN_ADDR;
                end
                3'd1: w.data[8:0] = c.rect.x0;
                3'd2: w.data[8:0] = c.rect.x1;
                3'd3: begin
                    w.rs        = 1'b0;
                    w.data[7:0] = lcd_image_pkg::OP_ROW_ADDR;
                end
                3'd4: w.data[8:0] = c.rect.y0;
                3'd5: w.data[8:0] = c.rect.y1;
                default: begin
                    w.rs        = 1'b0;
                    w.data[7:0] = lcd_image_pkg::OP_MEMORY_WRITE;
                end
            endcase
        end
        return w;
    endfunction

    assign is_write    = (cmd.opcode == lcd_image_pkg::CMD_WRITE_RECT);
    assign last_header = (cmd.opcode == lcd_image_pkg::CMD_CONFIGURE) ? (step == 3'd1)
                                                                       : (step == 3'd6);
    assign word_move   = word_valid && word_ready;
    assign req_ready   = (state == E_IDLE);
    assign pix_ready   = (state == E_DATA) && is_write && word_ready;
    // Bus must be idle so cs never rises under a low strobe
    assign frame_end   = (state == E_END) && word_ready;

    always_comb begin
        word       = header_word(cmd, step);
        word_valid = 1'b0;
        case (state)
            E_HEADER: word_valid = 1'b1;
            E_DATA: begin
                word.rs    = 1'b1;
                word.data  = is_write ? pixel : cmd.fill;
                word_valid = is_write ? pix_valid : 1'b1;
            end
            default: word_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= E_IDLE;
        end else begin
            case (state)
                E_IDLE: begin
                    if (req_valid) begin
                        state <= E_HEADER;
                    end
                end
                E_HEADER: begin
                    if (abort) begin
                        state <= E_END;
                    end else if (word_move && last_header) begin
                        state <= is_write || cmd.opcode == lcd_image_pkg::CMD_FILL_RECT
                                 ? E_DATA : E_END;
                    end
                end
                E_DATA: begin
                    if (abort || (word_move && remaining == 20'd1)) begin
                        state <= E_END;
                    end
                end
                default: begin
                    if (word_ready) begin
                        state <= E_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == E_IDLE && req_valid) begin
            cmd       <= request;
            step      <= 3'd0;
            remaining <= ({1'b0, request.rect.x1} - {1'b0, request.rect.x0} + 10'd1)
                       * ({1'b0, request.rect.y1} - {1'b0, request.rect.y0} + 10'd1);
        end else if (word_move) begin
            if (state == E_HEADER) begin
                step <= step + 3'd1;
            end else begin
                remaining <= remaining - 20'd1;
            end
        end
    end

endmodule

// ==== src/lcd_bus_writer.sv ====
`timescale 1ns/100ps

module lcd_bus_writer (
    input  logic                     clock,
    input  logic                     reset,
    input  lcd_image_pkg::lcd_word_t word,
    input  logic                     word_valid,
    output logic                     word_ready,
    input  logic                     frame_end,
    output logic [15:0]              lcd_db,
    output logic                     lcd_rs,
    output logic                     lcd_wr,
    output logic                     lcd_cs
);

    localparam int PhaseCycles = lcd_image_pkg::WR_LOW_CYCLES + lcd_image_pkg::WR_HIGH_CYCLES;
    localparam int PhaseWidth  = $clog2(PhaseCycles + 1);

    logic [PhaseWidth-1:0] phase;
    logic                  accept;

    assign word_ready = (phase == '0);
    assign accept     = word_valid && word_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase  <= '0;
            lcd_wr <= 1'b1;
            lcd_cs <= 1'b1;
        end else if (accept) begin
            phase  <= PhaseWidth'(PhaseCycles);
            lcd_wr <= 1'b0;
            lcd_cs <= 1'b0;
        end else begin
            if (phase != '0) begin
                phase <= phase - 1'b1;
            end
            // Rising strobe latches the word into the panel
            if (phase == PhaseWidth'(lcd_image_pkg::WR_HIGH_CYCLES + 1)) begin
                lcd_wr <= 1'b1;
            end
            if (frame_end) begin
                lcd_cs <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            lcd_db <= word.data;
            lcd_rs <= word.rs;
        end
    end

endmodule

// ==== src/lcd_image_top.sv ====
`timescale 1ns/100ps

module lcd_image_top #(
    parameter int LcdWidth      = 480,
    parameter int LcdHeight     = 320,
    parameter int ImageX        = 0,
    parameter int ImageY        = 0,
    parameter int ImageWidth    = 64,
    parameter int ImageHeight   = 64,
    parameter int TimeoutCycles = 4000
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       refresh_req,
    output logic                       refresh_ack,
    input  lcd_image_pkg::image_beat_t image_beat,
    input  logic                       image_valid,
    output logic                       image_ready,
    output logic                       image_cancel,
    output logic [15:0]                lcd_db,
    output logic                       lcd_rs,
    output logic                       lcd_wr,
    output logic                       lcd_cs,
    output logic                       configuring,
    output logic                       running,
    output logic                       busy
);

    lcd_image_pkg::lcd_request_t request;
    logic                        req_valid;
    logic                        req_ready;
    logic                        window_open;
    logic                        pixel_taken;
    lcd_image_pkg::pixel_t       pixel;
    logic                        pix_valid;
    logic                        pix_ready;
    logic                        abort;
    lcd_image_pkg::lcd_word_t    word;
    logic                        word_valid;
    logic                        word_ready;
    logic                        frame_end;

    frame_sequencer #(
        .LcdWidth      (LcdWidth),
        .LcdHeight     (LcdHeight),
        .ImageX        (ImageX),
        .ImageY        (ImageY),
        .ImageWidth    (ImageWidth),
        .ImageHeight   (ImageHeight),
        .TimeoutCycles (TimeoutCycles)
    ) sequencer0 (
        .clock        (clock),
        .reset        (reset),
        .refresh_req  (refresh_req),
        .refresh_ack  (refresh_ack),
        .request      (request),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .window_open  (window_open),
        .pixel_taken  (pixel_taken),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .abort        (abort),
        .image_cancel (image_cancel),
        .configuring  (configuring),
        .running      (running),
        .busy         (busy)
    );

    pixel_skid_buffer skid0 (
        .clock       (clock),
        .reset       (reset),
        .window_open (window_open),
        .image_beat  (image_beat),
        .image_valid (image_valid),
        .image_ready (image_ready),
        .pixel_taken (pixel_taken),
        .pixel       (pixel),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready)
    );

    lcd_command_engine engine0 (
        .clock      (clock),
        .reset      (reset),
        .request    (request),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .pixel      (pixel),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .abort      (abort),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .frame_end  (frame_end)
    );

    lcd_bus_writer writer0 (
        .clock      (clock),
        .reset      (reset),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .frame_end  (frame_end),
        .lcd_db     (lcd_db),
        .lcd_rs     (lcd_rs),
        .lcd_wr     (lcd_wr),
        .lcd_cs     (lcd_cs)
    );

endmodule

// ==== verif/lcd_image_props.sv ====
`timescale 1ns/100ps

module lcd_image_props (
    input logic clock,
    input logic reset,
    input logic refresh_req,
    input logic refresh_ack,
    input logic image_cancel,
    input logic lcd_wr,
    input logic lcd_cs,
    input logic busy
);

    // Ack only answers a pending request
    ack_needs_req: assert property (
        @(posedge clock) disable iff (reset) $rose(refresh_ack) |-> $past(refresh_req)
    ) else $error("refresh_ack rose while refresh_req was low");

    cancel_single_cycle: assert property (
        @(posedge clock) disable iff (reset) $rose(image_cancel) |=> !image_cancel
    ) else $error("image_cancel held longer than one cycle");

    // Strobe stays inside chip select
    wr_inside_cs: assert property (
        @(posedge clock) disable iff (reset) !lcd_wr |-> !lcd_cs
    ) else $error("lcd_wr low while lcd_cs high");

    ack_while_busy: assert property (
        @(posedge clock) disable iff (reset) refresh_ack |-> busy
    ) else $error("refresh_ack high while busy low");

endmodule

bind lcd_image_top lcd_image_props props0 (
    .clock        (clock),
    .reset        (reset),
    .refresh_req  (refresh_req),
    .refresh_ack  (refresh_ack),
    .image_cancel (image_cancel),
    .lcd_wr       (lcd_wr),
    .lcd_cs       (lcd_cs),
    .busy         (busy)
);

// ==== verif/lcd_image_tb.sv ====
`timescale 1ns/100ps

module lcd_image_tb;

    localparam int LcdWidth      = 8;
    localparam int LcdHeight     = 4;
    localparam int ImageX        = 2;
    localparam int ImageY        = 1;
    localparam int ImageWidth    = 4;
    localparam int ImageHeight   = 2;
    localparam int TimeoutCycles = 40;
    localparam int Rows          = 5;

    typedef enum logic [1:0] {
        FRAME_NORMAL,
        FRAME_STALLED,
        FRAME_STARVED,
        FRAME_ABORT
    } frame_kind_e;

    typedef struct packed {
        frame_kind_e kind;
        logic [7:0]  seed_offset;
        logic [3:0]  pixel_count;
    } frame_row_t;

    // Kind, seed offset, pixels sent from the start flag on
    frame_row_t frame_table [Rows] = '{
        '{FRAME_NORMAL,  8'd0, 4'd8},
        '{FRAME_STALLED, 8'd1, 4'd8},
        '{FRAME_STARVED, 8'd2, 4'd8},
        '{FRAME_ABORT,   8'd3, 4'd3},
        '{FRAME_NORMAL,  8'd4, 4'd8}
    };

    logic                       clock = 1'b0;
    logic                       reset;
    logic                       refresh_req;
    logic                       refresh_ack;
    lcd_image_pkg::image_beat_t image_beat;
    logic                       image_valid;
    logic                       image_ready;
    logic                       image_cancel;
    logic [15:0]                lcd_db;
    logic                       lcd_rs;
    logic                       lcd_wr;
    logic                       lcd_cs;
    logic                       configuring;
    logic                       running;
    logic                       busy;

    logic [16:0]                expect_q [$];
    logic [17:0]                seen_q [$];
    // Two beats without the start flag, then the frame pixels
    lcd_image_pkg::image_beat_t beats [10];
    logic [31:0]                rnd_state;
    int                         errors = 0;
    int                         cancel_count = 0;
    int                         cycle_count = 0;
    int                         cycle_limit = 0;

    lcd_image_top #(
        .LcdWidth      (LcdWidth),
        .LcdHeight     (LcdHeight),
        .ImageX        (ImageX),
        .ImageY        (ImageY),
        .ImageWidth    (ImageWidth),
        .ImageHeight   (ImageHeight),
        .TimeoutCycles (TimeoutCycles)
    ) dut0 (
        .clock        (clock),
        .reset        (reset),
        .refresh_req  (refresh_req),
        .refresh_ack  (refresh_ack),
        .image_beat   (image_beat),
        .image_valid  (image_valid),
        .image_ready  (image_ready),
        .image_cancel (image_cancel),
        .lcd_db       (lcd_db),
        .lcd_rs       (lcd_rs),
        .lcd_wr       (lcd_wr),
        .lcd_cs       (lcd_cs),
        .configuring  (configuring),
        .running      (running),
        .busy         (busy)
    );

    always #4 clock = ~clock;

    // Panel latches on the rising strobe
    always @(posedge lcd_wr) begin
        if (!reset) begin
            seen_q.push_back({lcd_cs, lcd_rs, lcd_db});
        end
    end

    always @(negedge clock) begin
        if (!reset && image_cancel) begin
            cancel_count = cancel_count + 1;
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_fail(input string msg);
        errors = errors + 1;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // Column and row window, then memory write
    task automatic push_window(input int x0, input int x1, input int y0, input int y1);
        expect_q.push_back({1'b0, 16'h002a});
        expect_q.push_back({1'b1, 16'(x0)});
        expect_q.push_back({1'b1, 16'(x1)});
        expect_q.push_back({1'b0, 16'h002b});
        expect_q.push_back({1'b1, 16'(y0)});
        expect_q.push_back({1'b1, 16'(y1)});
        expect_q.push_back({1'b0, 16'h002c});
    endtask

    task automatic compare_words(input string what);
        int i;
        logic [17:0] seen;
        if (seen_q.size() != expect_q.size()) begin
            report_fail($sformatf("%s: %0d bus words, expected %0d", what,
                                  seen_q.size(), expect_q.size()));
        end
        for (i = 0; i < expect_q.size() && i < seen_q.size(); i++) begin
            seen = seen_q[i];
            if (seen[17] != 1'b0) begin
                report_fail($sformatf("%s word %0d latched with cs high", what, i));
            end
            if (seen[16:0] != expect_q[i]) begin
                report_fail($sformatf("%s word %0d: rs %b db %h, expected rs %b db %h", what,
                                      i, seen[16], seen[15:0], expect_q[i][16],
                                      expect_q[i][15:0]));
            end
        end
        seen_q.delete();
        expect_q.delete();
    endtask

    task automatic send_beats(input frame_kind_e kind, input int count);
        int b;
        int gap;
        logic accepted;
        b = 0;
        while (b < count + 2) begin
            image_beat  = beats[b];
            image_valid = 1'b1;
            @(negedge clock);
            accepted = image_ready;
            next_cycle();
            if (accepted) begin
                b = b + 1;
                image_valid = 1'b0;
                gap = 0;
                if (kind == FRAME_STALLED && (b == 5 || b == 8)) begin
                    gap = 20;
                end else if (kind == FRAME_STARVED) begin
                    rnd_state = xorshift(rnd_state);
                    gap = int'(rnd_state[1:0]);
                end
                repeat (gap) next_cycle();
            end
        end
        image_valid = 1'b0;
    endtask

    task automatic run_frame(input int index, input frame_row_t row);
        int i;
        rnd_state = 32'h53aa + row.seed_offset;
        for (i = 0; i < row.pixel_count + 2; i++) begin
            rnd_state = xorshift(rnd_state);
            beats[i].pixel = rnd_state[15:0];
            beats[i].start = (i == 2);
        end
        // Image rectangle at 2,1 with size 4 by 2
        push_window(2, 5, 1, 2);
        for (i = 2; i < row.pixel_count + 2; i++) begin
            expect_q.push_back({1'b1, beats[i].pixel});
        end
        cancel_count = 0;
        refresh_req  = 1'b1;
        send_beats(row.kind, row.pixel_count);
        while (!refresh_ack) @(negedge clock);
        // Ack has to wait for the request to drop
        repeat (2) begin
            next_cycle();
            @(negedge clock);
            if (!refresh_ack) begin
                report_fail($sformatf("frame %0d: refresh_ack fell under refresh_req", index));
            end
        end
        next_cycle();
        refresh_req = 1'b0;
        while (refresh_ack) @(negedge clock);
        if (busy) begin
            report_fail($sformatf("frame %0d: busy high between frames", index));
        end
        if (image_ready) begin
            report_fail($sformatf("frame %0d: image_ready high with the window closed", index));
        end
        if (!lcd_cs) begin
            report_fail($sformatf("frame %0d: lcd_cs low after the frame", index));
        end
        if (cancel_count != ((row.kind == FRAME_ABORT) ? 1 : 0)) begin
            report_fail($sformatf("frame %0d: %0d image_cancel pulses", index, cancel_count));
        end
        compare_words($sformatf("frame %0d", index));
        next_cycle();
    endtask

    initial begin
        int r;
        int words;
        reset       = 1'b1;
        refresh_req = 1'b0;
        image_valid = 1'b0;
        image_beat  = '0;
        // Configure and fill words, then one window per table row
        words = 2 + 7 + LcdWidth * LcdHeight;
        for (r = 0; r < Rows; r++) begin
            words = words + 7 + frame_table[r].pixel_count;
        end
        cycle_limit = words * 40;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        expect_q.push_back({1'b0, 16'h0001});
        expect_q.push_back({1'b0, 16'h0029});
        // Whole 8 by 4 screen
        push_window(0, 7, 0, 3);
        repeat (LcdWidth * LcdHeight) expect_q.push_back({1'b1, 16'h0001});

        while (!configuring) @(negedge clock);
        if (!busy) begin
            report_fail("busy low during configuration");
        end
        while (!running) @(negedge clock);
        if (busy || configuring) begin
            report_fail("busy or configuring still high once running");
        end
        compare_words("configuration");

        next_cycle();
        for (r = 0; r < Rows; r++) begin
            run_frame(r, frame_table[r]);
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/lcd_image_pkg.sv
src/frame_sequencer.sv
src/pixel_skid_buffer.sv
src/lcd_command_engine.sv
src/lcd_bus_writer.sv
src/lcd_image_top.sv
verif/lcd_image_props.sv
verif/lcd_image_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lcd_image_tb -f verilog.f \
    && ./obj_dir/Vlcd_image_tb > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
